// File: rtl/uart_pkg.sv
//##########################################################################
// uart_pkg
// character format of the serial line and bit timing helpers, shared by
// the byte transmitter and the byte receiver
//##########################################################################
package uart_pkg;

	localparam int DATA_BITS  = 8;
	localparam int STOP_BITS  = 1;
	localparam int FRAME_BITS = 1 + DATA_BITS + STOP_BITS;	// start + data + stop

	// line levels
	localparam logic LINE_IDLE   = 1'b1;
	localparam logic START_LEVEL = 1'b0;

	// clock cycles per bit, rounded to the nearest cycle
	function automatic int bit_clks(input int clk_freq, input int baud_rate);
		return (clk_freq + baud_rate / 2) / baud_rate;
	endfunction

	// offset of the sample point from the start of a bit
	function automatic int half_bit_clks(input int clk_freq, input int baud_rate);
		return bit_clks(clk_freq, baud_rate) / 2;
	endfunction

endpackage

// File: rtl/frame_pkg.sv
//##########################################################################
// frame_pkg
// string framing on the serial link: delimiter character and count,
// state encodings of the transmit framer and the receive deframer
//##########################################################################
package frame_pkg;

	localparam logic [7:0] DELIM_CHAR  = 8'h26;	// '&'
	localparam int         DELIM_COUNT = 2;		// on each side of the payload

	// one-hot, transmit framer
	typedef enum logic [4:0] {
		TX_IDLE      = 5'b00001,
		TX_LEAD      = 5'b00010,
		TX_PAYLOAD   = 5'b00100,
		TX_TRAIL     = 5'b01000,
		TX_WAIT_LAST = 5'b10000	// last '&' on the line
	} tx_state_t;

	// receive deframer
	typedef enum logic [1:0] {
		RX_HUNT  = 2'd0,
		RX_LEAD2 = 2'd1,
		RX_BODY  = 2'd2,
		RX_AMP   = 2'd3	// one '&' seen inside the body
	} rx_state_t;

endpackage

// File: rtl/uart_tx.sv
//##########################################################################
// uart_tx
// byte transmitter, sends start bit, data bits LSB first and stop bit,
// each one bit time long
//##########################################################################
module uart_tx #(
	parameter int CLK_FREQ  = 50_000_000,
	parameter int BAUD_RATE = 115_200
) (
	input  logic                           sys_clk,
	input  logic                           sys_rst_n,
	input  logic [uart_pkg::DATA_BITS-1:0] byte_data,
	input  logic                           byte_req,
	output logic                           byte_busy,
	output logic                           byte_done,
	output logic                           tx
);
	import uart_pkg::*;

	localparam int BIT_CLKS = bit_clks(CLK_FREQ, BAUD_RATE);
	localparam int CLK_W    = $clog2(BIT_CLKS);
	localparam int BIT_W    = $clog2(FRAME_BITS);
	localparam int SHIFT_W  = DATA_BITS + STOP_BITS;

	logic [CLK_W-1:0]   clk_cnt;
	logic [BIT_W-1:0]   bit_cnt;	// 0 is the start bit
	logic [SHIFT_W-1:0] shifter;	// bit 0 goes out next
	logic               bit_end;
	logic               stop_end;

	assign bit_end = (clk_cnt == CLK_W'(BIT_CLKS - 1));

	// one cycle early, so done lands in the last stop cycle
	assign stop_end = (bit_cnt == BIT_W'(FRAME_BITS - 1)) &&
		(clk_cnt == CLK_W'(BIT_CLKS - 2));

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			byte_busy <= 1'b0;
			byte_done <= 1'b0;
			clk_cnt   <= '0;
			bit_cnt   <= '0;
			shifter   <= '1;
			tx        <= LINE_IDLE;
		end else begin
			byte_done <= 1'b0;
			if (!byte_busy) begin
				if (byte_req) begin
					byte_busy <= 1'b1;
					shifter   <= {{STOP_BITS{LINE_IDLE}}, byte_data};
					tx        <= START_LEVEL;
				end
			end else if (stop_end) begin
				// line stays high, a new byte may start next cycle
				byte_busy <= 1'b0;
				byte_done <= 1'b1;
				clk_cnt   <= '0;
				bit_cnt   <= '0;
			end else if (bit_end) begin
				clk_cnt <= '0;
				bit_cnt <= bit_cnt + 1'b1;
				tx      <= shifter[0];
				shifter <= {LINE_IDLE, shifter[SHIFT_W-1:1]};	// refill with idle
			end else begin
				clk_cnt <= clk_cnt + 1'b1;
			end
		end
	end

endmodule

// File: rtl/uart_rx.sv
//##########################################################################
// uart_rx
// byte receiver, two-flop line synchroniser, start edge detect, mid-bit
// sampling and a one-cycle valid strobe at the stop bit
//##########################################################################
module uart_rx #(
	parameter int CLK_FREQ  = 50_000_000,
	parameter int BAUD_RATE = 115_200
) (
	input  logic                           sys_clk,
	input  logic                           sys_rst_n,
	input  logic                           rx,
	output logic [uart_pkg::DATA_BITS-1:0] rx_byte,
	output logic                           rx_vld
);
	import uart_pkg::*;

	localparam int BIT_CLKS  = bit_clks(CLK_FREQ, BAUD_RATE);
	localparam int HALF_CLKS = half_bit_clks(CLK_FREQ, BAUD_RATE);
	localparam int CLK_W     = $clog2(BIT_CLKS);
	localparam int BIT_W     = $clog2(FRAME_BITS);

	logic                 rx_meta;
	logic                 rx_sync;
	logic                 rx_prev;	// for the falling edge
	logic                 busy;
	logic [CLK_W-1:0]     clk_cnt;
	logic [BIT_W-1:0]     bit_cnt;
	logic [DATA_BITS-1:0] shifter;
	logic                 sample;
	logic                 in_data;
	logic                 in_stop;

	assign sample  = busy && (clk_cnt == CLK_W'(HALF_CLKS - 1));
	assign in_data = (bit_cnt != '0) && (bit_cnt <= BIT_W'(DATA_BITS));
	assign in_stop = (bit_cnt == BIT_W'(FRAME_BITS - 1));

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rx_meta <= LINE_IDLE;
			rx_sync <= LINE_IDLE;
			rx_prev <= LINE_IDLE;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
			rx_prev <= rx_sync;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			busy    <= 1'b0;
			clk_cnt <= '0;
			bit_cnt <= '0;
			rx_vld  <= 1'b0;
		end else begin
			rx_vld <= 1'b0;
			if (!busy) begin
				if (rx_prev && !rx_sync) begin
					busy    <= 1'b1;
					clk_cnt <= '0;
					bit_cnt <= '0;
				end
			end else begin
				if (clk_cnt == CLK_W'(BIT_CLKS - 1)) begin
					clk_cnt <= '0;
					bit_cnt <= bit_cnt + 1'b1;
				end else begin
					clk_cnt <= clk_cnt + 1'b1;
				end
				if (sample && bit_cnt == '0 && rx_sync) begin
					busy <= 1'b0;	// glitch, not a start bit
				end
				if (sample && in_stop) begin
					busy   <= 1'b0;	// back to idle at mid stop bit
					rx_vld <= rx_sync;	// low stop bit drops the byte
				end
			end
		end
	end

	// data path
	always_ff @(posedge sys_clk) begin
		if (sample && in_data) begin
			shifter <= {rx_sync, shifter[DATA_BITS-1:1]};	// LSB first
		end
		if (sample && in_stop) begin
			rx_byte <= shifter;
		end
	end

endmodule

// File: rtl/frame_tx.sv
//##########################################################################
// frame_tx
// transmit framer, sends "&&", the payload and "&&" one byte at a time
//##########################################################################
module frame_tx #(
	parameter int MAX_CHARS = 137
) (
	input  logic                   sys_clk,
	input  logic                   sys_rst_n,
	input  logic [MAX_CHARS*8-1:0] tx_string,
	input  logic [7:0]             tx_length,
	input  logic                   tx_req,
	output logic                   tx_busy,
	output logic                   tx_done,
	output logic [7:0]             byte_data,
	output logic                   byte_req,
	input  logic                   byte_done
);
	import frame_pkg::*;

	localparam int DCNT_W = $clog2(DELIM_COUNT + 1);

	tx_state_t              state;
	logic [MAX_CHARS*8-1:0] str_q;
	logic [7:0]             len_q;	// clamped to MAX_CHARS
	logic [7:0]             idx;	// next payload character
	logic [DCNT_W-1:0]      delim_cnt;	// delimiters issued on this side
	logic                   accept;

	assign tx_done = (state == TX_WAIT_LAST) && byte_done;
	assign tx_busy = (state != TX_IDLE) && !tx_done;
	assign accept  = tx_req && !tx_busy;

	always_ff @(posedge sys_clk) begin
		if (accept) begin
			str_q <= tx_string;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state     <= TX_IDLE;
			len_q     <= '0;
			idx       <= '0;
			delim_cnt <= '0;
			byte_data <= '0;
			byte_req  <= 1'b0;
		end else begin
			byte_req <= 1'b0;
			if (accept) begin
				state     <= TX_LEAD;
				len_q     <= (tx_length > MAX_CHARS) ? 8'(MAX_CHARS) : tx_length;
				delim_cnt <= DCNT_W'(1);
				byte_data <= DELIM_CHAR;
				byte_req  <= 1'b1;
			end else if (byte_done) begin
				byte_req <= (state != TX_WAIT_LAST);
				case (state)
					TX_LEAD: begin
						if (delim_cnt < DELIM_COUNT) begin
							delim_cnt <= delim_cnt + 1'b1;
							byte_data <= DELIM_CHAR;
						end else if (len_q == '0) begin
							state     <= TX_TRAIL;	// empty payload
							delim_cnt <= DCNT_W'(1);
							byte_data <= DELIM_CHAR;
						end else begin
							state     <= TX_PAYLOAD;
							idx       <= 8'd1;
							byte_data <= str_q[7:0];
						end
					end
					TX_PAYLOAD: begin
						if (idx < len_q) begin
							idx       <= idx + 1'b1;
							byte_data <= str_q[idx*8 +: 8];
						end else begin
							state     <= TX_TRAIL;
							delim_cnt <= DCNT_W'(1);
							byte_data <= DELIM_CHAR;
						end
					end
					TX_TRAIL: begin
						delim_cnt <= delim_cnt + 1'b1;
						byte_data <= DELIM_CHAR;
						if (delim_cnt == DCNT_W'(DELIM_COUNT - 1)) begin
							state <= TX_WAIT_LAST;
						end
					end
					default: begin
						state <= TX_IDLE;	// last byte_done, also seen as tx_done
					end
				endcase
			end
		end
	end

endmodule

// File: rtl/frame_rx.sv
//##########################################################################
// frame_rx
// receive deframer, finds "&&" framing in the byte stream and collects
// the payload into the output string
//##########################################################################
module frame_rx #(
	parameter int MAX_CHARS = 137
) (
	input  logic                   sys_clk,
	input  logic                   sys_rst_n,
	input  logic [7:0]             rx_byte,
	input  logic                   rx_vld,
	output logic [MAX_CHARS*8-1:0] rx_string,
	output logic [7:0]             rx_length,
	output logic                   rx_busy,
	output logic                   rx_done,
	output logic                   rx_overflow
);
	import frame_pkg::*;

	rx_state_t              state;
	logic [MAX_CHARS*8-1:0] work;	// frame being assembled
	logic [7:0]             cnt;	// stored characters, saturates at MAX_CHARS
	logic                   is_delim;

	assign is_delim = (rx_byte == DELIM_CHAR);

	// working buffer, cleared at start of frame so unused bytes read zero
	always_ff @(posedge sys_clk) begin
		if (rx_vld) begin
			case (state)
				RX_LEAD2: begin
					if (is_delim) begin
						work <= '0;
					end
				end
				RX_BODY: begin
					if (!is_delim && cnt < MAX_CHARS) begin
						work[cnt*8 +: 8] <= rx_byte;
					end
				end
				RX_AMP: begin
					if (!is_delim) begin
						// the held '&' was payload after all
						if (cnt < MAX_CHARS) begin
							work[cnt*8 +: 8] <= DELIM_CHAR;
						end
						if (cnt + 1 < MAX_CHARS) begin
							work[(cnt+1)*8 +: 8] <= rx_byte;
						end
					end
				end
				default: begin
				end
			endcase
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state       <= RX_HUNT;
			cnt         <= '0;
			rx_string   <= '0;
			rx_length   <= '0;
			rx_busy     <= 1'b0;
			rx_done     <= 1'b0;
			rx_overflow <= 1'b0;
		end else begin
			rx_done <= 1'b0;
			if (rx_vld) begin
				case (state)
					RX_HUNT: begin
						if (is_delim) begin
							state <= RX_LEAD2;
						end
					end
					RX_LEAD2: begin
						if (is_delim) begin
							state       <= RX_BODY;	// start of frame
							cnt         <= '0;
							rx_busy     <= 1'b1;
							rx_overflow <= 1'b0;
						end else begin
							state <= RX_HUNT;
						end
					end
					RX_BODY: begin
						if (is_delim) begin
							state <= RX_AMP;
						end else if (cnt < MAX_CHARS) begin
							cnt <= cnt + 1'b1;
						end else begin
							rx_overflow <= 1'b1;
						end
					end
					default: begin
						if (is_delim) begin
							state     <= RX_HUNT;	// "&&" closes the frame
							rx_string <= work;
							rx_length <= cnt;
							rx_busy   <= 1'b0;
							rx_done   <= 1'b1;
						end else begin
							state <= RX_BODY;
							if (cnt + 2 <= MAX_CHARS) begin
								cnt <= cnt + 8'd2;
							end else begin
								cnt         <= 8'(MAX_CHARS);
								rx_overflow <= 1'b1;
							end
						end
					end
				endcase
			end
		end
	end

endmodule

// File: rtl/uart_string_link.sv
//##########################################################################
// uart_string_link
// string link top, transmit framer into the byte transmitter and byte
// receiver into the receive deframer
//##########################################################################
module uart_string_link #(
	parameter int CLK_FREQ  = 50_000_000,
	parameter int BAUD_RATE = 115_200,
	parameter int MAX_CHARS = 137
) (
	input  logic                   sys_clk,
	input  logic                   sys_rst_n,

	input  logic [MAX_CHARS*8-1:0] tx_string,
	input  logic [7:0]             tx_length,
	input  logic                   tx_req,
	output logic                   tx_busy,
	output logic                   tx_done,

	output logic [MAX_CHARS*8-1:0] rx_string,
	output logic [7:0]             rx_length,
	output logic                   rx_busy,
	output logic                   rx_done,
	output logic                   rx_overflow,

	input  logic                   uart_rx_port,
	output logic                   uart_tx_port
);

	logic [7:0] byte_data;
	logic       byte_req;
	logic       byte_done;
	logic [7:0] rx_byte;
	logic       rx_vld;

	frame_tx #(
		.MAX_CHARS (MAX_CHARS)
	) u_frame_tx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.tx_string (tx_string),
		.tx_length (tx_length),
		.tx_req    (tx_req),
		.tx_busy   (tx_busy),
		.tx_done   (tx_done),
		.byte_data (byte_data),
		.byte_req  (byte_req),
		.byte_done (byte_done)
	);

	// framer paces itself on byte_done, busy level not needed
	uart_tx #(
		.CLK_FREQ  (CLK_FREQ),
		.BAUD_RATE (BAUD_RATE)
	) u_uart_tx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.byte_data (byte_data),
		.byte_req  (byte_req),
		.byte_busy (),
		.byte_done (byte_done),
		.tx        (uart_tx_port)
	);

	uart_rx #(
		.CLK_FREQ  (CLK_FREQ),
		.BAUD_RATE (BAUD_RATE)
	) u_uart_rx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.rx        (uart_rx_port),
		.rx_byte   (rx_byte),
		.rx_vld    (rx_vld)
	);

	frame_rx #(
		.MAX_CHARS (MAX_CHARS)
	) u_frame_rx (
		.sys_clk     (sys_clk),
		.sys_rst_n   (sys_rst_n),
		.rx_byte     (rx_byte),
		.rx_vld      (rx_vld),
		.rx_string   (rx_string),
		.rx_length   (rx_length),
		.rx_busy     (rx_busy),
		.rx_done     (rx_done),
		.rx_overflow (rx_overflow)
	);

endmodule

// File: verification/tb_clock_gen.sv
//##########################################################################
// tb_clock_gen
// free running testbench clock, low at time zero
//##########################################################################
module tb_clock_gen #(
	parameter int PERIOD = 10
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

endmodule

// File: verification/tb_uart_string_link.sv
//##########################################################################
// tb_uart_string_link
// testbench for the string link, loopback and raw serial stimulus checked
// against a queue of expected frames, with a cycle limit on the run
//##########################################################################
module tb_uart_string_link;
	import uart_pkg::*;
	import frame_pkg::*;

	localparam int CLK_FREQ   = 1_000_000;
	localparam int BAUD_RATE  = 100_000;
	localparam int MAX_CHARS  = 16;
	localparam int SW         = MAX_CHARS * 8;
	localparam int BIT_CLKS   = bit_clks(CLK_FREQ, BAUD_RATE);
	// worst case characters per test, frames carry 4 delimiters
	localparam int TEST_CHARS = 20 * 20 + 3 * 20 + 4 + 5 * 20 + 72;
	localparam int CYCLE_LIMIT = TEST_CHARS * FRAME_BITS * BIT_CLKS * 12 / 10;

	logic          sys_clk;
	logic          sys_rst_n;
	logic [SW-1:0] tx_string;
	logic [7:0]    tx_length;
	logic          tx_req;
	logic          tx_busy, tx_done;
	logic [SW-1:0] rx_string;
	logic [7:0]    rx_length;
	logic          rx_busy, rx_done, rx_overflow;
	logic          uart_rx_port, uart_tx_port;
	logic          use_loop;	// 1 loopback, 0 serial driver
	logic          drv_line;
	logic          rx_busy_q;	// rx_busy one falling edge earlier

	integer        seed;
	int            err_count, check_count, tests_failed;
	int            req_count, done_count, cycle_cnt;
	logic [7:0]    payload [0:19];
	int            pay_len;
	logic [SW-1:0] exp_str [$];	// reference model
	int            exp_len [$];
	logic          exp_ovf [$];

	tb_clock_gen #(.PERIOD(10)) u_clk (.clk(sys_clk));

	uart_string_link #(
		.CLK_FREQ  (CLK_FREQ),
		.BAUD_RATE (BAUD_RATE),
		.MAX_CHARS (MAX_CHARS)
	) uut (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.tx_string    (tx_string),
		.tx_length    (tx_length),
		.tx_req       (tx_req),
		.tx_busy      (tx_busy),
		.tx_done      (tx_done),
		.rx_string    (rx_string),
		.rx_length    (rx_length),
		.rx_busy      (rx_busy),
		.rx_done      (rx_done),
		.rx_overflow  (rx_overflow),
		.uart_rx_port (uart_rx_port),
		.uart_tx_port (uart_tx_port)
	);

	assign uart_rx_port = use_loop ? uart_tx_port : drv_line;

	task automatic check_value(input string name, input logic [SW-1:0] exp,
		input logic [SW-1:0] act);
		check_count++;
		if (act !== exp) begin
			$display("Mismatch at %0t: %s expected %0h got %0h", $time, name, exp, act);
			err_count++;
		end
	endtask

	task automatic wait_clocks(input int n);
		repeat (n) @(posedge sys_clk);
		#1;	// inputs change just after the edge
	endtask

	function automatic int rand_range(input int lo, input int hi);
		return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
	endfunction

	// printable, never a delimiter
	function automatic logic [7:0] rand_char();
		logic [7:0] c;
		c = 8'(rand_range(8'h21, 8'h7e));
		if (c == DELIM_CHAR) c = 8'h2a;
		return c;
	endfunction

	task automatic make_payload(input int len, input bit with_amp);
		pay_len = len;
		for (int i = 0; i < len; i++) payload[i] = rand_char();
		if (with_amp) payload[rand_range(1, len - 2)] = DELIM_CHAR;	// isolated '&'
	endtask

	// expected string, truncated to capacity, unused bytes zero
	function automatic logic [SW-1:0] pack_payload();
		logic [SW-1:0] s;
		s = '0;
		for (int i = 0; i < pay_len && i < MAX_CHARS; i++) s[i*8 +: 8] = payload[i];
		return s;
	endfunction

	task automatic push_model();
		exp_str.push_back(pack_payload());
		exp_len.push_back((pay_len > MAX_CHARS) ? MAX_CHARS : pay_len);
		exp_ovf.push_back(pay_len > MAX_CHARS);
	endtask

	task automatic wait_drained();
		while (exp_len.size() != 0) wait_clocks(1);
	endtask

	// one frame through the transmitter, optionally a tx_req while busy
	task automatic send_frame(input bit poke);
		int k;
		while (tx_busy) wait_clocks(1);
		push_model();
		tx_string = pack_payload();
		tx_length = 8'(pay_len);
		tx_req    = 1'b1;
		wait_clocks(1);
		tx_req = 1'b0;
		req_count++;
		k = 0;
		while (!tx_done) begin
			if (!tx_busy) begin
				$display("Error at %0t: tx_busy fell before tx_done", $time);
				err_count++;
				break;
			end
			tx_req = poke && (k == 50);
			wait_clocks(1);
			k++;
		end
		tx_req = 1'b0;
		wait_drained();
	endtask

	task automatic drive_char(input logic [7:0] c);
		drv_line = 1'b0;	// start bit
		wait_clocks(BIT_CLKS);
		for (int i = 0; i < DATA_BITS; i++) begin
			drv_line = c[i];
			wait_clocks(BIT_CLKS);
		end
		drv_line = 1'b1;
		wait_clocks(BIT_CLKS * STOP_BITS);
	endtask

	task automatic drive_frame();
		push_model();
		repeat (DELIM_COUNT) drive_char(DELIM_CHAR);
		for (int i = 0; i < pay_len; i++) drive_char(payload[i]);
		repeat (DELIM_COUNT) drive_char(DELIM_CHAR);
		wait_drained();
	endtask

	task automatic report_test(input int num, input string name, input int errs_at_start);
		if (err_count == errs_at_start) begin
			$display("test %0d %s: ok", num, name);
		end else begin
			$display("test %0d %s: %0d errors", num, name, err_count - errs_at_start);
			tests_failed++;
		end
	endtask

	// sampled on the falling edge, away from the DUT updates
	always @(negedge sys_clk) begin
		if (sys_rst_n && tx_done) done_count++;
		if (sys_rst_n && rx_done) begin
			// busy held through the frame, dropped together with done
			check_value("rx_busy before rx_done", 1, rx_busy_q);
			check_value("rx_busy", 0, rx_busy);
			if (exp_len.size() == 0) begin
				$display("Error at %0t: rx_done with no frame expected", $time);
				err_count++;
			end else begin
				check_value("rx_string", exp_str.pop_front(), rx_string);
				check_value("rx_length", exp_len.pop_front(), rx_length);
				check_value("rx_overflow", exp_ovf.pop_front(), rx_overflow);
			end
		end
		rx_busy_q = rx_busy;
	end

	always @(posedge sys_clk) begin
		cycle_cnt++;
		if (cycle_cnt >= CYCLE_LIMIT) begin
			$display("Error: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("*** FAILED ***");
			$finish;
		end
	end

	initial begin
		int e0, r0, d0;
		seed = 32'h8c9d68e7;
		sys_rst_n = 1'b0;
		tx_string = '0;
		tx_length = '0;
		tx_req    = 1'b0;
		use_loop  = 1'b1;
		drv_line  = 1'b1;
		{err_count, check_count, tests_failed} = '0;
		{req_count, done_count, cycle_cnt} = '0;
		wait_clocks(5);
		sys_rst_n = 1'b1;
		check_value("uart_tx_port", 1, uart_tx_port);
		check_value("rx_string", 0, rx_string);
		check_value("rx_length", 0, rx_length);
		check_value("rx_busy", 0, rx_busy);
		check_value("rx_overflow", 0, rx_overflow);

		e0 = err_count;
		for (int n = 0; n < 20; n++) begin
			make_payload(rand_range(1, MAX_CHARS), 1'b0);
			send_frame(1'b0);
		end
		report_test(1, "random loopback", e0);

		e0 = err_count;
		r0 = req_count;
		d0 = done_count;
		for (int n = 0; n < 3; n++) begin
			make_payload(rand_range(1, MAX_CHARS), 1'b0);
			send_frame(1'b1);
		end
		wait_clocks(2 * BIT_CLKS);	// no frame started by the ignored request
		check_value("tx_busy", 0, tx_busy);
		check_value("tx_done count", req_count - r0, done_count - d0);
		report_test(2, "transmit control", e0);

		e0 = err_count;
		make_payload(0, 1'b0);
		send_frame(1'b0);
		report_test(3, "zero length", e0);

		e0 = err_count;
		for (int n = 0; n < 5; n++) begin
			make_payload(rand_range(3, MAX_CHARS), 1'b1);
			send_frame(1'b0);
		end
		report_test(4, "embedded delimiter", e0);

		e0 = err_count;
		use_loop = 1'b0;
		for (int n = 0; n < 6; n++) begin
			payload[0] = 8'($random(seed));
			if (payload[0] == DELIM_CHAR) payload[0] = 8'h00;
			drive_char(payload[0]);
		end
		drive_char(DELIM_CHAR);	// lone '&' then a letter
		drive_char(8'h51);
		make_payload(rand_range(1, MAX_CHARS), 1'b0);
		drive_frame();
		make_payload(20, 1'b0);
		drive_frame();
		make_payload(rand_range(1, MAX_CHARS), 1'b0);
		drive_frame();
		use_loop = 1'b1;
		report_test(5, "noise and overflow", e0);

		$display("tests 5, failed %0d, checks %0d, errors %0d",
			tests_failed, check_count, err_count);
		if (err_count == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

// File: sources.f
rtl/uart_pkg.sv
rtl/frame_pkg.sv
rtl/uart_tx.sv
rtl/uart_rx.sv
rtl/frame_tx.sv
rtl/frame_rx.sv
rtl/uart_string_link.sv
verification/tb_clock_gen.sv
verification/tb_uart_string_link.sv
